//--- rtl/rmt_cfg.svh
`ifndef RMT_CFG_SVH
`define RMT_CFG_SVH

// stream widths
`define RMT_DATA_W 64
`define RMT_USER_W 16

// vlan id sits in the low bits of the first beat
`define RMT_VLAN_W 12

// one store-and-forward lane per queue
`define RMT_NUM_QUEUES 4

// beats per lane, also the credit count after reset
`define RMT_LANE_DEPTH 16

`endif

//--- rtl/rmt_pkg.sv
`include "rmt_cfg.svh"

package rmt_pkg;

	typedef logic [`RMT_DATA_W-1:0]                data_t;
	typedef logic [`RMT_DATA_W/8-1:0]              keep_t;
	typedef logic [`RMT_USER_W-1:0]                user_t;
	typedef logic [`RMT_VLAN_W-1:0]                vlan_t;
	typedef logic [$clog2(`RMT_NUM_QUEUES)-1:0]    queue_t;
	typedef logic [$clog2(`RMT_LANE_DEPTH+1)-1:0]  credit_t;	// 0 up to full depth

	typedef enum logic [1:0] {
		FILT_HEAD,
		FILT_PASS,
		FILT_DROP
	} filt_state_t;

	typedef enum logic {
		ARB_IDLE,
		ARB_SEND
	} arb_state_t;

endpackage

//--- rtl/pkt_filter.sv
module pkt_filter
	import rmt_pkg::*;
(
	input  logic        clk,
	input  logic        aresetn,
	input  logic [31:0] vlan_drop_flags,
	input  data_t       s_axis_tdata,
	input  keep_t       s_axis_tkeep,
	input  user_t       s_axis_tuser,
	input  logic        s_axis_tvalid,
	output logic        s_axis_tready,
	input  logic        s_axis_tlast,
	output data_t       flt_data,
	output keep_t       flt_keep,
	output user_t       flt_user,
	output logic        flt_last,
	output queue_t      flt_queue,
	output logic        flt_valid,
	input  logic        flt_ready
);
	filt_state_t state;
	queue_t      pkt_queue;	// queue of the packet in progress
	vlan_t       vid;
	queue_t      head_queue;
	logic        head_drop;
	logic        accept;
	logic        load;

	assign vid = s_axis_tdata[$bits(vlan_t)-1:0];
	assign head_queue = vid[$bits(queue_t)-1:0];
	assign head_drop = vlan_drop_flags[vid[4:0]];

	// dropped beats never need the output register
	assign s_axis_tready = (state == FILT_DROP) || !flt_valid || flt_ready;
	assign accept = s_axis_tvalid && s_axis_tready;
	assign load = accept && ((state == FILT_HEAD && !head_drop) || state == FILT_PASS);

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state <= FILT_HEAD;
			pkt_queue <= '0;
			flt_valid <= 1'b0;
		end else begin
			if (load)
				flt_valid <= 1'b1;
			else if (flt_ready)
				flt_valid <= 1'b0;	// drained

			if (accept) begin
				case (state)
				FILT_HEAD: begin
					pkt_queue <= head_queue;
					// single beat packets stay in head
					if (!s_axis_tlast)
						state <= head_drop ? FILT_DROP : FILT_PASS;
				end
				default: begin
					if (s_axis_tlast)
						state <= FILT_HEAD;
				end
				endcase
			end
		end
	end

	// one entry output register
	always_ff @(posedge clk) begin
		if (load) begin
			flt_data <= s_axis_tdata;
			flt_keep <= s_axis_tkeep;
			flt_user <= s_axis_tuser;
			flt_last <= s_axis_tlast;
			flt_queue <= (state == FILT_HEAD) ? head_queue : pkt_queue;
		end
	end

endmodule

//--- rtl/queue_dispatch.sv
`include "rmt_cfg.svh"

module queue_dispatch
	import rmt_pkg::*;
(
	input  logic                       clk,
	input  logic                       aresetn,
	input  data_t                      flt_data,
	input  keep_t                      flt_keep,
	input  user_t                      flt_user,
	input  logic                       flt_last,
	input  queue_t                     flt_queue,
	input  logic                       flt_valid,
	output logic                       flt_ready,
	input  logic [`RMT_NUM_QUEUES-1:0] credit_ret,
	output logic [`RMT_NUM_QUEUES-1:0] lane_wr,
	output data_t                      wr_data,
	output keep_t                      wr_keep,
	output user_t                      wr_user,
	output logic                       wr_last
);
	credit_t credit [`RMT_NUM_QUEUES];	// free slots per lane
	logic    wr_beat;

	// stall the filter while the tagged lane is out of credit
	assign flt_ready = (credit[flt_queue] != '0);
	assign wr_beat = flt_valid && flt_ready;

	always_comb begin
		for (int i = 0; i < `RMT_NUM_QUEUES; i++)
			lane_wr[i] = wr_beat && (flt_queue == queue_t'(i));
	end

	// beat fields go to all lanes, only the strobe selects
	assign wr_data = flt_data;
	assign wr_keep = flt_keep;
	assign wr_user = flt_user;
	assign wr_last = flt_last;

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			for (int i = 0; i < `RMT_NUM_QUEUES; i++)
				credit[i] <= credit_t'(`RMT_LANE_DEPTH);
		end else begin
			// write and return may land in the same cycle
			for (int i = 0; i < `RMT_NUM_QUEUES; i++)
				credit[i] <= credit[i] + credit_t'(credit_ret[i]) - credit_t'(lane_wr[i]);
		end
	end

endmodule

//--- rtl/queue_lane.sv
`include "rmt_cfg.svh"

module queue_lane
	import rmt_pkg::*;
(
	input  logic  clk,
	input  logic  aresetn,
	input  logic  wr_en,
	input  data_t wr_data,
	input  keep_t wr_keep,
	input  user_t wr_user,
	input  logic  wr_last,
	input  logic  rd_en,
	output logic  credit_ret,
	output logic  lane_valid,
	output data_t rd_data,
	output keep_t rd_keep,
	output user_t rd_user,
	output logic  rd_last
);
	localparam int PTR_W = $clog2(`RMT_LANE_DEPTH);

	data_t mem_data [`RMT_LANE_DEPTH];
	keep_t mem_keep [`RMT_LANE_DEPTH];
	user_t mem_user [`RMT_LANE_DEPTH];
	logic  [`RMT_LANE_DEPTH-1:0] mem_last;

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	credit_t          pkt_cnt;	// complete packets held
	logic             pkt_in;
	logic             pkt_out;

	assign pkt_in = wr_en && wr_last;
	assign pkt_out = rd_en && rd_last;

	// only whole packets are offered downstream
	assign lane_valid = (pkt_cnt != '0);

	// fall-through head
	assign rd_data = mem_data[rd_ptr];
	assign rd_keep = mem_keep[rd_ptr];
	assign rd_user = mem_user[rd_ptr];
	assign rd_last = mem_last[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem_data[wr_ptr] <= wr_data;
			mem_keep[wr_ptr] <= wr_keep;
			mem_user[wr_ptr] <= wr_user;
			mem_last[wr_ptr] <= wr_last;
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			pkt_cnt <= '0;
			credit_ret <= 1'b0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;	// depth is a power of two, wraps
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			pkt_cnt <= pkt_cnt + credit_t'(pkt_in) - credit_t'(pkt_out);
			// one credit back per popped beat
			credit_ret <= rd_en;
		end
	end

endmodule

//--- rtl/output_arbiter.sv
`include "rmt_cfg.svh"

module output_arbiter
	import rmt_pkg::*;
(
	input  logic                       clk,
	input  logic                       aresetn,
	input  logic [`RMT_NUM_QUEUES-1:0] lane_valid,
	input  data_t                      lane_data [`RMT_NUM_QUEUES],
	input  keep_t                      lane_keep [`RMT_NUM_QUEUES],
	input  user_t                      lane_user [`RMT_NUM_QUEUES],
	input  logic [`RMT_NUM_QUEUES-1:0] lane_last,
	output logic [`RMT_NUM_QUEUES-1:0] lane_rd,
	output data_t                      m_axis_tdata,
	output keep_t                      m_axis_tkeep,
	output user_t                      m_axis_tuser,
	output logic                       m_axis_tvalid,
	input  logic                       m_axis_tready,
	output logic                       m_axis_tlast
);
	arb_state_t state;
	queue_t     grant;	// lane being sent, or the last one served
	queue_t     next_lane;
	queue_t     cand;
	logic       found;
	logic       xfer;

	// search starts just after the last served lane
	always_comb begin
		next_lane = grant;
		found = 1'b0;
		cand = grant;
		for (int k = 1; k <= `RMT_NUM_QUEUES; k++) begin
			cand = queue_t'(grant + k);
			if (!found && lane_valid[cand]) begin
				next_lane = cand;
				found = 1'b1;
			end
		end
	end

	assign m_axis_tvalid = (state == ARB_SEND) && lane_valid[grant];
	assign m_axis_tdata = lane_data[grant];
	assign m_axis_tkeep = lane_keep[grant];
	assign m_axis_tuser = lane_user[grant];
	assign m_axis_tlast = lane_last[grant];
	assign xfer = m_axis_tvalid && m_axis_tready;

	always_comb begin
		for (int i = 0; i < `RMT_NUM_QUEUES; i++)
			lane_rd[i] = xfer && (grant == queue_t'(i));
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state <= ARB_IDLE;
			grant <= queue_t'(`RMT_NUM_QUEUES - 1);	// lane 0 goes first
		end else begin
			case (state)
			ARB_IDLE: begin
				if (found) begin
					grant <= next_lane;
					state <= ARB_SEND;
				end
			end
			ARB_SEND: begin
				// hold the grant for the whole packet
				if (xfer && m_axis_tlast)
					state <= ARB_IDLE;
			end
			default: state <= ARB_IDLE;
			endcase
		end
	end

endmodule

//--- rtl/rmt_wrapper.sv
`include "rmt_cfg.svh"

module rmt_wrapper
	import rmt_pkg::*;
(
	input  logic        clk,
	input  logic        aresetn,
	input  logic [31:0] vlan_drop_flags,
	input  data_t       s_axis_tdata,
	input  keep_t       s_axis_tkeep,
	input  user_t       s_axis_tuser,
	input  logic        s_axis_tvalid,
	output logic        s_axis_tready,
	input  logic        s_axis_tlast,
	output data_t       m_axis_tdata,
	output keep_t       m_axis_tkeep,
	output user_t       m_axis_tuser,
	output logic        m_axis_tvalid,
	input  logic        m_axis_tready,
	output logic        m_axis_tlast
);
	// filter to dispatcher
	data_t  flt_data;
	keep_t  flt_keep;
	user_t  flt_user;
	logic   flt_last;
	queue_t flt_queue;
	logic   flt_valid;
	logic   flt_ready;

	// dispatcher to lanes, beat fields shared
	wire [`RMT_NUM_QUEUES-1:0] lane_wr;
	wire [`RMT_NUM_QUEUES-1:0] credit_ret;
	data_t wr_data;
	keep_t wr_keep;
	user_t wr_user;
	logic  wr_last;

	// lane heads towards the arbiter
	wire [`RMT_NUM_QUEUES-1:0] lane_valid;
	wire [`RMT_NUM_QUEUES-1:0] lane_rd;
	wire [`RMT_NUM_QUEUES-1:0] lane_last;
	wire data_t lane_data [`RMT_NUM_QUEUES];
	wire keep_t lane_keep [`RMT_NUM_QUEUES];
	wire user_t lane_user [`RMT_NUM_QUEUES];

	pkt_filter filter_i (
		.clk             (clk),
		.aresetn         (aresetn),
		.vlan_drop_flags (vlan_drop_flags),
		.s_axis_tdata    (s_axis_tdata),
		.s_axis_tkeep    (s_axis_tkeep),
		.s_axis_tuser    (s_axis_tuser),
		.s_axis_tvalid   (s_axis_tvalid),
		.s_axis_tready   (s_axis_tready),
		.s_axis_tlast    (s_axis_tlast),
		.flt_data        (flt_data),
		.flt_keep        (flt_keep),
		.flt_user        (flt_user),
		.flt_last        (flt_last),
		.flt_queue       (flt_queue),
		.flt_valid       (flt_valid),
		.flt_ready       (flt_ready)
	);

	queue_dispatch dispatch_i (
		.clk        (clk),
		.aresetn    (aresetn),
		.flt_data   (flt_data),
		.flt_keep   (flt_keep),
		.flt_user   (flt_user),
		.flt_last   (flt_last),
		.flt_queue  (flt_queue),
		.flt_valid  (flt_valid),
		.flt_ready  (flt_ready),
		.credit_ret (credit_ret),
		.lane_wr    (lane_wr),
		.wr_data    (wr_data),
		.wr_keep    (wr_keep),
		.wr_user    (wr_user),
		.wr_last    (wr_last)
	);

	for (genvar i = 0; i < `RMT_NUM_QUEUES; i++) begin : g_lane
		queue_lane lane_i (
			.clk        (clk),
			.aresetn    (aresetn),
			.wr_en      (lane_wr[i]),
			.wr_data    (wr_data),
			.wr_keep    (wr_keep),
			.wr_user    (wr_user),
			.wr_last    (wr_last),
			.rd_en      (lane_rd[i]),
			.credit_ret (credit_ret[i]),
			.lane_valid (lane_valid[i]),
			.rd_data    (lane_data[i]),
			.rd_keep    (lane_keep[i]),
			.rd_user    (lane_user[i]),
			.rd_last    (lane_last[i])
		);
	end

	output_arbiter arbiter_i (
		.clk           (clk),
		.aresetn       (aresetn),
		.lane_valid    (lane_valid),
		.lane_data     (lane_data),
		.lane_keep     (lane_keep),
		.lane_user     (lane_user),
		.lane_last     (lane_last),
		.lane_rd       (lane_rd),
		.m_axis_tdata  (m_axis_tdata),
		.m_axis_tkeep  (m_axis_tkeep),
		.m_axis_tuser  (m_axis_tuser),
		.m_axis_tvalid (m_axis_tvalid),
		.m_axis_tready (m_axis_tready),
		.m_axis_tlast  (m_axis_tlast)
	);

endmodule

//--- tb/rmt_wrapper_chk.sv
`include "rmt_cfg.svh"

module rmt_wrapper_chk
	import rmt_pkg::*;
(
	input logic                       clk,
	input logic                       aresetn,
	input logic                       m_axis_tvalid,
	input logic                       m_axis_tready,
	input data_t                      m_axis_tdata,
	input keep_t                      m_axis_tkeep,
	input user_t                      m_axis_tuser,
	input logic                       m_axis_tlast,
	input logic [`RMT_NUM_QUEUES-1:0] credit_ret
);
	int fail_count = 0;	// summed into the testbench error count

	// a stalled beat stays put until it is taken
	a_hold: assert property (@(posedge clk) disable iff (!aresetn)
		m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_tdata)
			&& $stable(m_axis_tkeep) && $stable(m_axis_tuser) && $stable(m_axis_tlast))
	else begin
		$error("master beat changed while stalled");
		fail_count++;
	end

	a_reset: assert property (@(posedge clk) !aresetn |=> !m_axis_tvalid)
	else begin
		$error("m_axis_tvalid high during reset");
		fail_count++;
	end

	// each master transfer gives back exactly one lane credit a cycle later
	a_pop: assert property (@(posedge clk) disable iff (!aresetn)
		((|credit_ret) == $past(m_axis_tvalid && m_axis_tready)) && $onehot0(credit_ret))
	else begin
		$error("lane credit return does not match the master transfers");
		fail_count++;
	end

endmodule

bind rmt_wrapper rmt_wrapper_chk chk_i (
	.clk           (clk),
	.aresetn       (aresetn),
	.m_axis_tvalid (m_axis_tvalid),
	.m_axis_tready (m_axis_tready),
	.m_axis_tdata  (m_axis_tdata),
	.m_axis_tkeep  (m_axis_tkeep),
	.m_axis_tuser  (m_axis_tuser),
	.m_axis_tlast  (m_axis_tlast),
	.credit_ret    (credit_ret)
);

//--- tb/rmt_wrapper_tb.sv
`include "rmt_cfg.svh"

module rmt_wrapper_tb
	import rmt_pkg::*;
();
	localparam int          N_PKTS = 80;
	localparam logic [31:0] DROP_FLAGS = 32'h2480_1204;
	localparam int          SEED = 32'h7005;

	typedef struct packed {
		logic  last;
		user_t user;
		keep_t keep;
		data_t data;
	} beat_t;

	logic        clk;
	logic        aresetn;
	logic [31:0] vlan_drop_flags;
	data_t       s_axis_tdata;
	keep_t       s_axis_tkeep;
	user_t       s_axis_tuser;
	logic        s_axis_tvalid;
	logic        s_axis_tready;
	logic        s_axis_tlast;
	data_t       m_axis_tdata;
	keep_t       m_axis_tkeep;
	user_t       m_axis_tuser;
	logic        m_axis_tvalid;
	logic        m_axis_tready = 1'b1;
	logic        m_axis_tlast;

	beat_t  stim_q [$];
	beat_t  exp_q [`RMT_NUM_QUEUES][$];	// expected beats per lane, in order
	int     stim_seed = SEED;
	int     ready_seed = SEED;	// own stream, independent of process order
	int     cycle_limit = 0;
	int     half_beat = 0;
	int     dropped_pkts = 0;
	int     val_errors = 0;
	int     other_errors = 0;
	logic   stall_phase;
	logic   saw_stall = 1'b0;
	logic   in_pkt = 1'b0;
	queue_t cur_q = '0;

	rmt_wrapper dut_i (
		.clk             (clk),
		.aresetn         (aresetn),
		.vlan_drop_flags (vlan_drop_flags),
		.s_axis_tdata    (s_axis_tdata),
		.s_axis_tkeep    (s_axis_tkeep),
		.s_axis_tuser    (s_axis_tuser),
		.s_axis_tvalid   (s_axis_tvalid),
		.s_axis_tready   (s_axis_tready),
		.s_axis_tlast    (s_axis_tlast),
		.m_axis_tdata    (m_axis_tdata),
		.m_axis_tkeep    (m_axis_tkeep),
		.m_axis_tuser    (m_axis_tuser),
		.m_axis_tvalid   (m_axis_tvalid),
		.m_axis_tready   (m_axis_tready),
		.m_axis_tlast    (m_axis_tlast)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			val_errors++;
			$display("[FAIL] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	// vlan id in the low bits of the first beat decides drop and lane
	function automatic void model_packet(int first, int len);
		vlan_t  vid;
		queue_t q;
		vid = stim_q[first].data[11:0];
		q = vid[1:0];
		if (DROP_FLAGS[vid[4:0]]) begin
			dropped_pkts++;
			return;
		end
		for (int b = 0; b < len; b++)
			exp_q[q].push_back(stim_q[first + b]);
	endfunction

	function automatic void build_packets();
		logic [31:0] rnd;
		int          len;
		int          first;
		beat_t       b;
		for (int p = 0; p < N_PKTS; p++) begin
			if (p == N_PKTS / 2)
				half_beat = stim_q.size();	// throttled output from here on
			rnd = $random(stim_seed);
			len = 1 + int'(rnd[2:0]);
			first = stim_q.size();
			for (int k = 0; k < len; k++) begin
				b.data[63:32] = $random(stim_seed);
				b.data[31:0] = $random(stim_seed);
				rnd = $random(stim_seed);
				b.keep = rnd[7:0];
				b.user = rnd[31:16];
				b.last = (k == len - 1);
				stim_q.push_back(b);
			end
			model_packet(first, len);
		end
	endfunction

	function automatic int expected_left();
		int n;
		n = 0;
		for (int q = 0; q < `RMT_NUM_QUEUES; q++)
			n += exp_q[q].size();
		return n;
	endfunction

	task automatic send_beat(input beat_t b);
		logic [31:0] rnd;
		s_axis_tdata <= b.data;
		s_axis_tkeep <= b.keep;
		s_axis_tuser <= b.user;
		s_axis_tlast <= b.last;
		s_axis_tvalid <= 1'b1;
		@(posedge clk);
		while (!s_axis_tready)
			@(posedge clk);
		rnd = $random(stim_seed);
		if (rnd[2:0] == 3'd0) begin	// idle gap now and then
			s_axis_tvalid <= 1'b0;
			@(posedge clk);
		end
	endtask

	task automatic finish_run();
		int left;
		int assert_fails;
		left = expected_left();
		assert_fails = dut_i.chk_i.fail_count;
		if (left != 0) begin
			other_errors++;
			$display("%0d expected beats never came out of the DUT", left);
		end
		if (!saw_stall) begin
			other_errors++;
			$display("s_axis_tready never fell while the output was throttled");
		end
		$display("errors: %0d value, %0d other, %0d assertion (%0d packets, %0d dropped)",
			val_errors, other_errors, assert_fails, N_PKTS, dropped_pkts);
		if (val_errors == 0 && other_errors == 0 && assert_fails == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	endtask

	// random stalls on the master side in the second half
	always @(posedge clk) begin
		logic [31:0] rnd;
		rnd = $random(ready_seed);
		m_axis_tready <= !stall_phase || (rnd[1:0] == 2'd0);
	end

	// compare output beats with the head of their lane's list
	always @(negedge clk) begin
		beat_t e;
		if (aresetn === 1'b1) begin
			if (stall_phase && s_axis_tvalid && !s_axis_tready)
				saw_stall = 1'b1;
			if (m_axis_tvalid && m_axis_tready) begin
				if (!in_pkt)
					cur_q = m_axis_tdata[1:0];
				if (exp_q[cur_q].size() == 0) begin
					other_errors++;
					$display("unexpected output beat for queue %0d, data 0x%0h", cur_q, m_axis_tdata);
				end else begin
					e = exp_q[cur_q].pop_front();
					check_value("m_axis_tdata", m_axis_tdata, e.data);
					check_value("m_axis_tkeep", 64'(m_axis_tkeep), 64'(e.keep));
					check_value("m_axis_tuser", 64'(m_axis_tuser), 64'(e.user));
					check_value("m_axis_tlast", 64'(m_axis_tlast), 64'(e.last));
				end
				in_pkt = !m_axis_tlast;
			end
		end
	end

	initial begin : watchdog
		int cycle_cnt;
		cycle_cnt = 0;
		wait (cycle_limit != 0);
		while (cycle_cnt < cycle_limit) begin
			@(posedge clk);
			cycle_cnt++;
		end
		other_errors++;
		$display("timeout after %0d cycles, output stream did not drain", cycle_cnt);
		finish_run();
	end

	initial begin : main
		aresetn <= 1'b0;
		vlan_drop_flags <= DROP_FLAGS;
		s_axis_tdata <= '0;
		s_axis_tkeep <= '0;
		s_axis_tuser <= '0;
		s_axis_tlast <= 1'b0;
		s_axis_tvalid <= 1'b0;
		stall_phase <= 1'b0;
		build_packets();
		cycle_limit = 40 * stim_q.size() + 200;
		repeat (2) @(posedge clk);
		aresetn <= 1'b1;
		@(negedge clk);
		check_value("m_axis_tvalid", 64'(m_axis_tvalid), 64'd0);
		check_value("s_axis_tready", 64'(s_axis_tready), 64'd1);
		@(posedge clk);
		for (int i = 0; i < stim_q.size(); i++) begin
			if (i == half_beat)
				stall_phase <= 1'b1;
			send_beat(stim_q[i]);
		end
		s_axis_tvalid <= 1'b0;
		while (expected_left() != 0)
			@(posedge clk);
		repeat (50) @(posedge clk);	// room for stray beats
		finish_run();
	end

endmodule

//--- rmt_wrapper.f
+incdir+rtl
rtl/rmt_pkg.sv
rtl/pkt_filter.sv
rtl/queue_dispatch.sv
rtl/queue_lane.sv
rtl/output_arbiter.sv
rtl/rmt_wrapper.sv
tb/rmt_wrapper_chk.sv
tb/rmt_wrapper_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
	-f rmt_wrapper.f --top-module rmt_wrapper_tb -Mdir obj_dir; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vrmt_wrapper_tb +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
	exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1
